//--- verilog.f
+incdir+src
src/noc_link_pkg.sv
src/vcache_pkg.sv
src/link_to_cache.sv
src/vcache.sv
src/axi_mem.sv
src/vcache_top.sv
tb/tb_vcache_top.sv

//--- Bender.yml
package:
  name: vcache_bank

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/noc_link_pkg.sv
      - src/vcache_pkg.sv
      - src/link_to_cache.sv
      - src/vcache.sv
      - src/axi_mem.sv
      - src/vcache_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_vcache_top.sv

//--- tb/tb_vcache_top.sv
// ==========================================================
// tb_vcache_top
// table-driven testbench for the victim-cache bank, with a
// word-level reference memory and a tag model for misses
// ==========================================================
`timescale 1ns/10ps
`include "vcache_consts.svh"

module tb_vcache_top;
  import noc_link_pkg::*;

  localparam int MAX_ENTRIES = 48;
  localparam int SWEEP_LEN   = 20;

  logic                         clk;
  logic                         reset;
  logic                         req_v_i;
  logic                         req_ready_o;
  link_op_e                     req_op_i;
  logic [`ADDR_WIDTH-1:0]       req_addr_i;
  logic [`DATA_WIDTH-1:0]       req_data_i;
  logic [`MASK_WIDTH-1:0]       req_mask_i;
  logic [`X_CORD_WIDTH-1:0]     req_src_x_i;
  logic [`Y_CORD_WIDTH-1:0]     req_src_y_i;
  logic [`LOAD_ID_WIDTH-1:0]    req_load_id_i;
  logic                         resp_v_o;
  logic                         resp_ready_i;
  link_op_e                     resp_op_o;
  logic [`DATA_WIDTH-1:0]       resp_data_o;
  logic [`LOAD_ID_WIDTH-1:0]    resp_load_id_o;
  logic [`X_CORD_WIDTH-1:0]     resp_dst_x_o;
  logic [`Y_CORD_WIDTH-1:0]     resp_dst_y_o;
  logic [`MISS_CTR_WIDTH-1:0]   miss_count_o;

  // stimulus table
  link_op_e                     e_op [MAX_ENTRIES];
  logic [`ADDR_WIDTH-1:0]       e_addr [MAX_ENTRIES];
  logic [`DATA_WIDTH-1:0]       e_data [MAX_ENTRIES];
  logic [`MASK_WIDTH-1:0]       e_mask [MAX_ENTRIES];
  logic [`X_CORD_WIDTH-1:0]     e_x [MAX_ENTRIES];
  logic [`Y_CORD_WIDTH-1:0]     e_y [MAX_ENTRIES];
  logic [`LOAD_ID_WIDTH-1:0]    e_id [MAX_ENTRIES];
  int                           e_stall [MAX_ENTRIES];
  int                           e_miss [MAX_ENTRIES];
  int                           n_entries;
  int                           issued;

  logic [`DATA_WIDTH-1:0]       ref_mem [1 << `ADDR_WIDTH];
  logic [`SETS-1:0]             model_valid;
  logic [`TAG_WIDTH-1:0]        model_tag [`SETS];
  int                           sweep_sets [3] = '{1, 7, 9};
  integer                       seed;
  int                           cycles;
  int                           cycle_limit;

  vcache_top UUT (
    .clk(clk), .reset(reset),
    .req_v_i(req_v_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
    .req_addr_i(req_addr_i), .req_data_i(req_data_i), .req_mask_i(req_mask_i),
    .req_src_x_i(req_src_x_i), .req_src_y_i(req_src_y_i),
    .req_load_id_i(req_load_id_i),
    .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i), .resp_op_o(resp_op_o),
    .resp_data_o(resp_data_o), .resp_load_id_o(resp_load_id_o),
    .resp_dst_x_o(resp_dst_x_o), .resp_dst_y_o(resp_dst_y_o),
    .miss_count_o(miss_count_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // watchdog on total run length
  always @(posedge clk) begin
    if (reset) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Testbench failed");
        $fatal(1, "cycle limit reached");
      end
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [`DATA_WIDTH-1:0] merge_bytes(input logic [`DATA_WIDTH-1:0] old,
      input logic [`DATA_WIDTH-1:0] data, input logic [`MASK_WIDTH-1:0] mask);
    logic [`DATA_WIDTH-1:0] res;
    res = old;
    for (int b = 0; b < `MASK_WIDTH; b++) begin
      if (mask[b])
        res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic add_entry(input link_op_e op, input logic [`ADDR_WIDTH-1:0] addr,
      input logic [`DATA_WIDTH-1:0] data, input logic [`MASK_WIDTH-1:0] mask,
      input logic [`X_CORD_WIDTH-1:0] x, input logic [`Y_CORD_WIDTH-1:0] y,
      input logic [`LOAD_ID_WIDTH-1:0] id, input int stall, input int miss);
    e_op[n_entries]    = op;
    e_addr[n_entries]  = addr;
    e_data[n_entries]  = data;
    e_mask[n_entries]  = mask;
    e_x[n_entries]     = x;
    e_y[n_entries]     = y;
    e_id[n_entries]    = id;
    e_stall[n_entries] = stall;
    e_miss[n_entries]  = miss;
    n_entries++;
  endtask

  task automatic build_table();
    int                      misses;
    logic [`INDEX_WIDTH-1:0] set;
    logic [`TAG_WIDTH-1:0]   tag;
    logic [`OFFSET_WIDTH-1:0] off;
    link_op_e                op;
    n_entries = 0;
    // cold load, stores into the same block, hits
    add_entry(LINK_LOAD,  12'h010, 32'h0,        4'h0, 2'd1, 2'd2, 4'd5, 0, 1);
    add_entry(LINK_STORE, 12'h010, 32'hdeadbeef, 4'hf, 2'd3, 2'd0, 4'd6, 0, 1);
    add_entry(LINK_STORE, 12'h011, 32'h12345678, 4'h5, 2'd0, 2'd1, 4'd7, 0, 1);
    add_entry(LINK_LOAD,  12'h011, 32'h0,        4'h0, 2'd2, 2'd3, 4'd8, 0, 1);
    add_entry(LINK_LOAD,  12'h010, 32'h0,        4'h0, 2'd1, 2'd1, 4'd9, 5, 1);
    // set 4 conflicts, dirty victims go back to DRAM
    add_entry(LINK_LOAD,  12'h410, 32'h0,        4'h0, 2'd3, 2'd3, 4'd10, 0, 2);
    add_entry(LINK_STORE, 12'h412, 32'ha5a5a5a5, 4'hc, 2'd0, 2'd2, 4'd11, 3, 2);
    add_entry(LINK_LOAD,  12'h011, 32'h0,        4'h0, 2'd2, 2'd0, 4'd12, 0, 3);
    add_entry(LINK_LOAD,  12'h412, 32'h0,        4'h0, 2'd1, 2'd3, 4'd13, 0, 4);
    // random sweep over sets untouched so far
    misses      = 4;
    model_valid = '0;
    for (int i = 0; i < SWEEP_LEN; i++) begin
      set = sweep_sets[{$random(seed)} % 3];
      tag = {$random(seed)} % 3;
      off = {$random(seed)} % `BLOCK_WORDS;
      op  = ($random(seed) & 1) ? LINK_STORE : LINK_LOAD;
      if (!model_valid[set] || model_tag[set] != tag) begin
        misses++;
        model_valid[set] = 1'b1;
        model_tag[set]   = tag;
      end
      add_entry(op, {tag, set, off}, $random(seed), $random(seed), $random(seed),
                $random(seed), $random(seed), (i % 7 == 3) ? 2 : 0, misses);
    end
    cycle_limit = 200 * n_entries;
  endtask

  task automatic send_request(input int i);
    req_v_i       = 1'b1;
    req_op_i      = e_op[i];
    req_addr_i    = e_addr[i];
    req_data_i    = e_data[i];
    req_mask_i    = e_mask[i];
    req_src_x_i   = e_x[i];
    req_src_y_i   = e_y[i];
    req_load_id_i = e_id[i];
    while (!req_ready_o)
      @(negedge clk);
    @(negedge clk);
    req_v_i = 1'b0;
    issued++;
  endtask

  task automatic run_entry(input int i);
    logic [`DATA_WIDTH-1:0]    exp_data;
    logic [`DATA_WIDTH-1:0]    held_data;
    logic [`LOAD_ID_WIDTH-1:0] held_id;
    link_op_e                  held_op;
    resp_ready_i = (e_stall[i] == 0);
    // a stalled response before may already have let this request in
    if (issued == i)
      send_request(i);
    while (!resp_v_o)
      @(negedge clk);
    exp_data = (e_op[i] == LINK_STORE) ? '0 : ref_mem[e_addr[i]];
    check_value(resp_op_o, e_op[i], "response opcode");
    check_value(resp_data_o, exp_data, "response data");
    check_value(resp_load_id_o, e_id[i], "response load id");
    check_value(resp_dst_x_o, e_x[i], "response x coordinate");
    check_value(resp_dst_y_o, e_y[i], "response y coordinate");
    check_value(miss_count_o, e_miss[i], "miss count");
    held_data = resp_data_o;
    held_id   = resp_load_id_o;
    held_op   = resp_op_o;
    // response must hold while the link stalls and the next request comes in
    for (int s = 0; s < e_stall[i]; s++) begin
      if (s == 0 && i + 1 < n_entries)
        send_request(i + 1);
      else
        @(negedge clk);
      check_value(resp_v_o, 1'b1, "valid dropped under back-pressure");
      check_value(resp_data_o, held_data, "data changed under back-pressure");
      check_value(resp_load_id_o, held_id, "load id changed under back-pressure");
      check_value(resp_op_o, held_op, "opcode changed under back-pressure");
    end
    resp_ready_i = 1'b1;
    @(negedge clk);
    check_value(resp_v_o, 1'b0, "response still valid after handshake");
    if (e_op[i] == LINK_STORE)
      ref_mem[e_addr[i]] = merge_bytes(ref_mem[e_addr[i]], e_data[i], e_mask[i]);
  endtask

  initial begin
    reset         = 1'b0;
    req_v_i       = 1'b0;
    req_op_i      = LINK_LOAD;
    req_addr_i    = '0;
    req_data_i    = '0;
    req_mask_i    = '0;
    req_src_x_i   = '0;
    req_src_y_i   = '0;
    req_load_id_i = '0;
    resp_ready_i  = 1'b1;
    cycles        = 0;
    issued        = 0;
    cycle_limit   = 200 * MAX_ENTRIES;
    seed          = 10;
    for (int a = 0; a < (1 << `ADDR_WIDTH); a++)
      ref_mem[a] = '0;
    build_table();
    repeat (16) @(negedge clk);
    check_value(req_ready_o, 1'b0, "req_ready_o high in reset");
    check_value(resp_v_o, 1'b0, "resp_v_o high in reset");
    check_value(miss_count_o, '0, "miss count not cleared by reset");
    reset = 1'b1;
    for (int i = 0; i < n_entries; i++)
      run_entry(i);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- src/vcache_top.sv
// ==========================================================
// vcache_top
// link adapter, cache bank and DRAM model of one memory tile
// ==========================================================
`timescale 1ns/10ps
`include "vcache_consts.svh"

module vcache_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_v_i,
  output logic                          req_ready_o,
  input  noc_link_pkg::link_op_e        req_op_i,
  input  logic [`ADDR_WIDTH-1:0]        req_addr_i,
  input  logic [`DATA_WIDTH-1:0]        req_data_i,
  input  logic [`MASK_WIDTH-1:0]        req_mask_i,
  input  logic [`X_CORD_WIDTH-1:0]      req_src_x_i,
  input  logic [`Y_CORD_WIDTH-1:0]      req_src_y_i,
  input  logic [`LOAD_ID_WIDTH-1:0]     req_load_id_i,
  output logic                          resp_v_o,
  input  logic                          resp_ready_i,
  output noc_link_pkg::link_op_e        resp_op_o,
  output logic [`DATA_WIDTH-1:0]        resp_data_o,
  output logic [`LOAD_ID_WIDTH-1:0]     resp_load_id_o,
  output logic [`X_CORD_WIDTH-1:0]      resp_dst_x_o,
  output logic [`Y_CORD_WIDTH-1:0]      resp_dst_y_o,
  output logic [`MISS_CTR_WIDTH-1:0]    miss_count_o
);
  import noc_link_pkg::*;

  logic                          cmd_v;
  logic                          cmd_ready;
  link_op_e                      cmd_op;
  logic [`ADDR_WIDTH-1:0]        cmd_addr;
  logic [`DATA_WIDTH-1:0]        cmd_data;
  logic [`MASK_WIDTH-1:0]        cmd_mask;
  logic                          cache_v;
  logic [`DATA_WIDTH-1:0]        cache_data;
  logic                          aw_v;
  logic                          aw_ready;
  logic [`BLOCK_ADDR_WIDTH-1:0]  aw_addr;
  logic                          w_v;
  logic                          w_ready;
  logic [`BLOCK_WIDTH-1:0]       w_data;
  logic                          b_v;
  logic                          b_ready;
  logic                          ar_v;
  logic                          ar_ready;
  logic [`BLOCK_ADDR_WIDTH-1:0]  ar_addr;
  logic                          r_v;
  logic                          r_ready;
  logic [`BLOCK_WIDTH-1:0]       r_data;

  link_to_cache link (
    .clk(clk), .reset(reset),
    .req_v_i(req_v_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
    .req_addr_i(req_addr_i), .req_data_i(req_data_i), .req_mask_i(req_mask_i),
    .req_src_x_i(req_src_x_i), .req_src_y_i(req_src_y_i),
    .req_load_id_i(req_load_id_i),
    .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i), .resp_op_o(resp_op_o),
    .resp_data_o(resp_data_o), .resp_load_id_o(resp_load_id_o),
    .resp_dst_x_o(resp_dst_x_o), .resp_dst_y_o(resp_dst_y_o),
    .cmd_v_o(cmd_v), .cmd_ready_i(cmd_ready), .cmd_op_o(cmd_op),
    .cmd_addr_o(cmd_addr), .cmd_data_o(cmd_data), .cmd_mask_o(cmd_mask),
    .cache_v_i(cache_v), .cache_data_i(cache_data)
  );

  vcache cache (
    .clk(clk), .reset(reset),
    .cmd_v_i(cmd_v), .cmd_ready_o(cmd_ready), .cmd_op_i(cmd_op),
    .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data), .cmd_mask_i(cmd_mask),
    .cache_v_o(cache_v), .cache_data_o(cache_data), .miss_count_o(miss_count_o),
    .aw_v_o(aw_v), .aw_ready_i(aw_ready), .aw_addr_o(aw_addr),
    .w_v_o(w_v), .w_ready_i(w_ready), .w_data_o(w_data),
    .b_v_i(b_v), .b_ready_o(b_ready),
    .ar_v_o(ar_v), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
    .r_v_i(r_v), .r_ready_o(r_ready), .r_data_i(r_data)
  );

  axi_mem dram (
    .clk(clk), .reset(reset),
    .aw_v_i(aw_v), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr),
    .w_v_i(w_v), .w_ready_o(w_ready), .w_data_i(w_data),
    .b_v_o(b_v), .b_ready_i(b_ready),
    .ar_v_i(ar_v), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
    .r_v_o(r_v), .r_ready_i(r_ready), .r_data_o(r_data)
  );

endmodule

//--- src/axi_mem.sv
// ==========================================================
// axi_mem
// single-beat AXI DRAM model, one read or write at a time
// with a fixed latency
// ==========================================================
`timescale 1ns/10ps
`include "vcache_consts.svh"

module axi_mem (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          aw_v_i,
  output logic                          aw_ready_o,
  input  logic [`BLOCK_ADDR_WIDTH-1:0]  aw_addr_i,
  input  logic                          w_v_i,
  output logic                          w_ready_o,
  input  logic [`BLOCK_WIDTH-1:0]       w_data_i,
  output logic                          b_v_o,
  input  logic                          b_ready_i,
  input  logic                          ar_v_i,
  output logic                          ar_ready_o,
  input  logic [`BLOCK_ADDR_WIDTH-1:0]  ar_addr_i,
  output logic                          r_v_o,
  input  logic                          r_ready_i,
  output logic [`BLOCK_WIDTH-1:0]       r_data_o
);

  typedef enum logic [1:0] {
    M_IDLE,
    M_READ,
    M_WRITE
  } mem_state_e;

  mem_state_e                     state_r;
  logic [`LAT_CTR_WIDTH-1:0]      cnt_r;
  logic [`BLOCK_ADDR_WIDTH-1:0]   rd_addr_r;
  logic [`BLOCK_WIDTH-1:0]        mem [`MEM_BLOCKS];
  logic                           idle;

  assign idle = (state_r == M_IDLE);

  // reads win, a write needs address and data together
  assign ar_ready_o = idle;
  assign aw_ready_o = idle && !ar_v_i && w_v_i;
  assign w_ready_o  = idle && !ar_v_i && aw_v_i;

  assign r_v_o    = (state_r == M_READ) && (cnt_r == '0);
  assign b_v_o    = (state_r == M_WRITE) && (cnt_r == '0);
  assign r_data_o = mem[rd_addr_r];

  always_ff @(posedge clk) begin
    if (!reset) begin
      state_r <= M_IDLE;
      cnt_r   <= '0;
      for (int i = 0; i < `MEM_BLOCKS; i++)
        mem[i] <= '0;
    end else begin
      case (state_r)
        M_IDLE: begin
          if (ar_v_i) begin
            state_r   <= M_READ;
            cnt_r     <= `LAT_CTR_WIDTH'(`MEM_LATENCY - 1);
            rd_addr_r <= ar_addr_i;
          end else if (aw_v_i && w_v_i) begin
            state_r        <= M_WRITE;
            cnt_r          <= `LAT_CTR_WIDTH'(`MEM_LATENCY - 1);
            mem[aw_addr_i] <= w_data_i;
          end
        end
        default: begin
          // count down, then hold the response until taken
          if (cnt_r != '0)
            cnt_r <= cnt_r - 1'b1;
          else if ((r_v_o && r_ready_i) || (b_v_o && b_ready_i))
            state_r <= M_IDLE;
        end
      endcase
    end
  end

endmodule

//--- src/vcache.sv
// ==========================================================
// vcache
// direct-mapped write-back cache bank, one command at a time,
// fills and evicts whole blocks over a single-beat AXI master
// ==========================================================
`timescale 1ns/10ps
`include "vcache_consts.svh"

module vcache (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            cmd_v_i,
  output logic                            cmd_ready_o,
  input  noc_link_pkg::link_op_e          cmd_op_i,
  input  logic [`ADDR_WIDTH-1:0]          cmd_addr_i,
  input  logic [`DATA_WIDTH-1:0]          cmd_data_i,
  input  logic [`MASK_WIDTH-1:0]          cmd_mask_i,
  output logic                            cache_v_o,
  output logic [`DATA_WIDTH-1:0]          cache_data_o,
  output logic [`MISS_CTR_WIDTH-1:0]      miss_count_o,
  output logic                            aw_v_o,
  input  logic                            aw_ready_i,
  output logic [`BLOCK_ADDR_WIDTH-1:0]    aw_addr_o,
  output logic                            w_v_o,
  input  logic                            w_ready_i,
  output logic [`BLOCK_WIDTH-1:0]         w_data_o,
  input  logic                            b_v_i,
  output logic                            b_ready_o,
  output logic                            ar_v_o,
  input  logic                            ar_ready_i,
  output logic [`BLOCK_ADDR_WIDTH-1:0]    ar_addr_o,
  input  logic                            r_v_i,
  output logic                            r_ready_o,
  input  logic [`BLOCK_WIDTH-1:0]         r_data_i
);
  import noc_link_pkg::*;
  import vcache_pkg::*;

  vcache_state_e                state_r;
  link_op_e                     op_r;
  logic [`ADDR_WIDTH-1:0]       addr_r;
  logic [`DATA_WIDTH-1:0]       wdata_r;
  logic [`MASK_WIDTH-1:0]       mask_r;
  logic [`DATA_WIDTH-1:0]       rdata_r;
  logic [`MISS_CTR_WIDTH-1:0]   miss_ctr_r;
  logic                         aw_done_r;
  logic                         w_done_r;

  logic [`BLOCK_WIDTH-1:0]      data_mem [`SETS];
  logic [`TAG_WIDTH-1:0]        tag_mem [`SETS];
  logic [`SETS-1:0]             valid_r;
  logic [`SETS-1:0]             dirty_r;

  logic [`OFFSET_WIDTH-1:0]     offset;
  logic [`INDEX_WIDTH-1:0]      index;
  logic [`TAG_WIDTH-1:0]        tag;
  logic                         hit;
  logic [`DATA_WIDTH-1:0]       word;
  logic [`DATA_WIDTH-1:0]       merged;
  logic                         aw_ok;
  logic                         w_ok;

  assign offset = addr_r[`OFFSET_WIDTH-1:0];
  assign index  = addr_r[`OFFSET_WIDTH +: `INDEX_WIDTH];
  assign tag    = addr_r[`ADDR_WIDTH-1 -: `TAG_WIDTH];
  assign hit    = valid_r[index] && (tag_mem[index] == tag);
  assign word   = data_mem[index][offset*`DATA_WIDTH +: `DATA_WIDTH];

  // byte merge of store data into the resident word
  always_comb begin
    merged = word;
    for (int b = 0; b < `MASK_WIDTH; b++) begin
      if (mask_r[b])
        merged[b*8 +: 8] = wdata_r[b*8 +: 8];
    end
  end

  // aw and w may be taken in different cycles
  assign aw_ok = aw_done_r || aw_ready_i;
  assign w_ok  = w_done_r || w_ready_i;

  assign cmd_ready_o  = (state_r == IDLE);
  assign cache_v_o    = (state_r == RESPOND);
  assign cache_data_o = rdata_r;
  assign miss_count_o = miss_ctr_r;

  // victim goes out at its own tag, fill comes in at the request tag
  assign aw_v_o    = (state_r == EVICT_ADDR) && !aw_done_r;
  assign aw_addr_o = {tag_mem[index], index};
  assign w_v_o     = (state_r == EVICT_ADDR) && !w_done_r;
  assign w_data_o  = data_mem[index];
  assign b_ready_o = (state_r == EVICT_RESP);
  assign ar_v_o    = (state_r == FILL_ADDR);
  assign ar_addr_o = {tag, index};
  assign r_ready_o = (state_r == FILL_WAIT);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state_r    <= IDLE;
      valid_r    <= '0;
      dirty_r    <= '0;
      miss_ctr_r <= '0;
      aw_done_r  <= 1'b0;
      w_done_r   <= 1'b0;
    end else begin
      case (state_r)
        IDLE: begin
          if (cmd_v_i)
            state_r <= LOOKUP;
        end
        LOOKUP: begin
          if (hit) begin
            state_r <= RESPOND;
            if (op_r == LINK_STORE)
              dirty_r[index] <= 1'b1;
          end else begin
            miss_ctr_r <= miss_ctr_r + 1'b1;
            if (valid_r[index] && dirty_r[index])
              state_r <= EVICT_ADDR;
            else
              state_r <= FILL_ADDR;
          end
        end
        EVICT_ADDR: begin
          if (aw_ok && w_ok) begin
            state_r   <= EVICT_RESP;
            aw_done_r <= 1'b0;
            w_done_r  <= 1'b0;
          end else begin
            aw_done_r <= aw_ok;
            w_done_r  <= w_ok;
          end
        end
        EVICT_RESP: begin
          if (b_v_i)
            state_r <= FILL_ADDR;
        end
        FILL_ADDR: begin
          if (ar_ready_i)
            state_r <= FILL_WAIT;
        end
        FILL_WAIT: begin
          // back to lookup, which now hits and finishes the access
          if (r_v_i) begin
            state_r        <= LOOKUP;
            valid_r[index] <= 1'b1;
            dirty_r[index] <= 1'b0;
          end
        end
        RESPOND: state_r <= IDLE;
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_v_i && cmd_ready_o) begin
      op_r    <= cmd_op_i;
      addr_r  <= cmd_addr_i;
      wdata_r <= cmd_data_i;
      mask_r  <= cmd_mask_i;
    end
    if (state_r == LOOKUP && hit) begin
      if (op_r == LINK_STORE) begin
        data_mem[index][offset*`DATA_WIDTH +: `DATA_WIDTH] <= merged;
        rdata_r <= '0;
      end else begin
        rdata_r <= word;
      end
    end
    if (state_r == FILL_WAIT && r_v_i) begin
      data_mem[index] <= r_data_i;
      tag_mem[index]  <= tag;
    end
  end

endmodule

//--- src/link_to_cache.sv
// ==========================================================
// link_to_cache
// turns link requests into cache commands and returns
// responses to the requesting tile
// ==========================================================
`timescale 1ns/10ps
`include "vcache_consts.svh"

module link_to_cache (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_v_i,
  output logic                          req_ready_o,
  input  noc_link_pkg::link_op_e        req_op_i,
  input  logic [`ADDR_WIDTH-1:0]        req_addr_i,
  input  logic [`DATA_WIDTH-1:0]        req_data_i,
  input  logic [`MASK_WIDTH-1:0]        req_mask_i,
  input  logic [`X_CORD_WIDTH-1:0]      req_src_x_i,
  input  logic [`Y_CORD_WIDTH-1:0]      req_src_y_i,
  input  logic [`LOAD_ID_WIDTH-1:0]     req_load_id_i,
  output logic                          resp_v_o,
  input  logic                          resp_ready_i,
  output noc_link_pkg::link_op_e        resp_op_o,
  output logic [`DATA_WIDTH-1:0]        resp_data_o,
  output logic [`LOAD_ID_WIDTH-1:0]     resp_load_id_o,
  output logic [`X_CORD_WIDTH-1:0]      resp_dst_x_o,
  output logic [`Y_CORD_WIDTH-1:0]      resp_dst_y_o,
  output logic                          cmd_v_o,
  input  logic                          cmd_ready_i,
  output noc_link_pkg::link_op_e        cmd_op_o,
  output logic [`ADDR_WIDTH-1:0]        cmd_addr_o,
  output logic [`DATA_WIDTH-1:0]        cmd_data_o,
  output logic [`MASK_WIDTH-1:0]        cmd_mask_o,
  input  logic                          cache_v_i,
  input  logic [`DATA_WIDTH-1:0]        cache_data_i
);
  import noc_link_pkg::*;

  logic                      en_r;
  logic                      pend_v_r;
  logic                      cmd_pend_r;
  link_op_e                  pend_op_r;
  logic [`ADDR_WIDTH-1:0]    pend_addr_r;
  logic [`DATA_WIDTH-1:0]    pend_data_r;
  logic [`MASK_WIDTH-1:0]    pend_mask_r;
  logic [`X_CORD_WIDTH-1:0]  pend_x_r;
  logic [`Y_CORD_WIDTH-1:0]  pend_y_r;
  logic [`LOAD_ID_WIDTH-1:0] pend_id_r;
  logic                      resp_v_r;
  logic                      req_fire;

  // one request in flight at a time
  assign req_ready_o = en_r && !pend_v_r;
  assign req_fire    = req_v_i && req_ready_o;

  // hold the command back while a response still waits on the link,
  // so the completion pulse always finds a free response slot
  assign cmd_v_o    = cmd_pend_r && !resp_v_r;
  assign cmd_op_o   = pend_op_r;
  assign cmd_addr_o = pend_addr_r;
  assign cmd_data_o = pend_data_r;
  assign cmd_mask_o = pend_mask_r;
  assign resp_v_o   = resp_v_r;

  always_ff @(posedge clk) begin
    if (!reset) begin
      en_r       <= 1'b0;
      pend_v_r   <= 1'b0;
      cmd_pend_r <= 1'b0;
      resp_v_r   <= 1'b0;
    end else begin
      en_r <= 1'b1;
      if (req_fire) begin
        pend_v_r   <= 1'b1;
        cmd_pend_r <= 1'b1;
      end else begin
        if (cmd_v_o && cmd_ready_i)
          cmd_pend_r <= 1'b0;
        if (cache_v_i)
          pend_v_r <= 1'b0;
      end
      if (cache_v_i)
        resp_v_r <= 1'b1;
      else if (resp_ready_i)
        resp_v_r <= 1'b0;
    end
  end

  // request payload and return routing
  always_ff @(posedge clk) begin
    if (req_fire) begin
      pend_op_r   <= req_op_i;
      pend_addr_r <= req_addr_i;
      pend_data_r <= req_data_i;
      pend_mask_r <= req_mask_i;
      pend_x_r    <= req_src_x_i;
      pend_y_r    <= req_src_y_i;
      pend_id_r   <= req_load_id_i;
    end
    if (cache_v_i) begin
      resp_op_o      <= pend_op_r;
      resp_data_o    <= cache_data_i;
      resp_load_id_o <= pend_id_r;
      resp_dst_x_o   <= pend_x_r;
      resp_dst_y_o   <= pend_y_r;
    end
  end

endmodule

//--- src/vcache_pkg.sv
// ==========================================================
// vcache_pkg
// controller states of the victim-cache bank
// ==========================================================
package vcache_pkg;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVICT_ADDR,
    EVICT_RESP,
    FILL_ADDR,
    FILL_WAIT,
    RESPOND
  } vcache_state_e;

endpackage

//--- src/noc_link_pkg.sv
// ==========================================================
// noc_link_pkg
// request opcodes carried on the tile network link
// ==========================================================
package noc_link_pkg;

  typedef enum logic [0:0] {
    LINK_LOAD  = 1'b0,
    LINK_STORE = 1'b1
  } link_op_e;

endpackage

//--- src/vcache_consts.svh
// ==========================================================
// vcache constants
// sizes of the cache bank, link fields and DRAM model
// ==========================================================
`ifndef VCACHE_CONSTS_SVH
`define VCACHE_CONSTS_SVH

`define DATA_WIDTH       32
`define ADDR_WIDTH       12
`define BLOCK_WORDS      4
`define BLOCK_WIDTH      128
`define SETS             16
`define X_CORD_WIDTH     2
`define Y_CORD_WIDTH     2
`define LOAD_ID_WIDTH    4
`define MEM_LATENCY      4
`define MISS_CTR_WIDTH   16

// derived widths
`define MASK_WIDTH       (`DATA_WIDTH / 8)
`define OFFSET_WIDTH     $clog2(`BLOCK_WORDS)
`define INDEX_WIDTH      $clog2(`SETS)
`define TAG_WIDTH        (`ADDR_WIDTH - `INDEX_WIDTH - `OFFSET_WIDTH)
`define BLOCK_ADDR_WIDTH (`ADDR_WIDTH - `OFFSET_WIDTH)
`define MEM_BLOCKS       (1 << `BLOCK_ADDR_WIDTH)
`define LAT_CTR_WIDTH    3

`endif
